//--- build.f
riscv_pkg.sv
stage_reg.sv
fetch_control.sv
instr_decoder.sv
reg_file.sv
execute_unit.sv
riscv_core.sv
tb_clock.sv
riscv_core_assert.sv
riscv_core_tb.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - riscv_pkg.sv
  - stage_reg.sv
  - fetch_control.sv
  - instr_decoder.sv
  - reg_file.sv
  - execute_unit.sv
  - riscv_core.sv
  - target: test
    files:
      - tb_clock.sv
      - riscv_core_assert.sv
      - riscv_core_tb.sv

//--- riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

    localparam logic [31:0] base_pc = 32'h0040_0000;
    localparam int prog_len = 40;
    localparam int reset_cycles = 5;
    localparam int timeout_cycles = prog_len * 6 + 50 + reset_cycles;
    // Entries 25 and 27 are loads, each one used by the next entry
    localparam int load_count = 2;
    localparam int load_use_stalls = 2;

    // kind 0 no effect, 1 register write, 2 store
    typedef struct packed {
        logic [31:0] instr;
        logic [1:0]  kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] addr;
        logic [2:0]  test;
    } entry_t;

    logic clk;
    logic rst;
    riscv_pkg::word_t pc;
    logic instr_req;
    riscv_pkg::word_t instr;
    riscv_pkg::dmem_req_t dmem;
    riscv_pkg::word_t d_rdata;
    riscv_pkg::retire_t retire;

    entry_t prog [prog_len];
    logic [31:0] imem [64];
    logic [31:0] dmem_arr [256];
    logic [31:0] fetched;
    logic [31:0] rdata_q;
    int ret_q [$];
    int store_q [$];
    int last_idx [1:6];
    int test_errors [1:6];
    string test_name [1:6];
    int errors;
    int checks;
    int stall_cycles;
    int load_reads;

    tb_clock #(.period(10.0)) clock_gen (.clk(clk));

    riscv_core #(.initial_pc(base_pc)) UUT (
        .clk(clk), .rst(rst), .pc(pc), .instr_req(instr_req), .instr(instr),
        .dmem(dmem), .d_rdata(d_rdata), .retire(retire)
    );

    ////////////////////
    // Instruction encoding
    ////////////////////

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        r_type = {f7, rs2, rs1, f3, rd, riscv_pkg::op_r};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [6:0] op);
        i_type = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::op_store};
    endfunction

    function automatic logic [31:0] beq(input logic [12:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        beq = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
               riscv_pkg::op_branch};
    endfunction

    function automatic entry_t writes(input logic [31:0] w, input logic [4:0] rd,
                                      input logic [31:0] data, input logic [2:0] test);
        writes = '{instr: w, kind: 2'd1, rd: rd, data: data, addr: '0, test: test};
    endfunction

    function automatic entry_t stores(input logic [31:0] w, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [2:0] test);
        stores = '{instr: w, kind: 2'd2, rd: '0, data: data, addr: addr, test: test};
    endfunction

    function automatic entry_t silent(input logic [31:0] w, input logic [2:0] test);
        silent = '{instr: w, kind: 2'd0, rd: '0, data: '0, addr: '0, test: test};
    endfunction

    ////////////////////
    // Program and expected results
    ////////////////////

    task automatic fill_program;
        // ALU ops, x1 = 5 and x2 = -3
        prog[0]  = writes(i_type(12'd5, 3'b000, 1, 0, riscv_pkg::op_i), 1, 32'd5, 1);
        prog[1]  = writes(i_type(-12'sd3, 3'b000, 2, 0, riscv_pkg::op_i), 2, 32'hffff_fffd, 1);
        prog[2]  = writes(r_type(7'h00, 3'b000, 3, 1, 2), 3, 32'd2, 1);
        prog[3]  = writes(r_type(7'h20, 3'b000, 4, 1, 2), 4, 32'd8, 1);
        prog[4]  = writes(r_type(7'h00, 3'b111, 5, 1, 2), 5, 32'd5, 1);
        prog[5]  = writes(r_type(7'h00, 3'b110, 6, 1, 2), 6, 32'hffff_fffd, 1);
        prog[6]  = writes(r_type(7'h00, 3'b100, 7, 1, 2), 7, 32'hffff_fff8, 1);
        prog[7]  = writes(r_type(7'h00, 3'b010, 8, 2, 1), 8, 32'd1, 1);
        prog[8]  = writes(r_type(7'h00, 3'b010, 9, 1, 2), 9, 32'd0, 1);
        prog[9]  = writes(r_type(7'h00, 3'b001, 10, 1, 1), 10, 32'h0000_00a0, 1);
        prog[10] = writes(r_type(7'h00, 3'b101, 11, 2, 1), 11, 32'h07ff_ffff, 1);
        prog[11] = writes(r_type(7'h20, 3'b101, 12, 2, 1), 12, 32'hffff_ffff, 1);
        prog[12] = writes(i_type(12'h0f0, 3'b111, 13, 2, riscv_pkg::op_i), 13, 32'hf0, 1);
        prog[13] = writes(i_type(12'h100, 3'b110, 14, 1, riscv_pkg::op_i), 14, 32'h105, 1);
        prog[14] = writes(i_type(12'hfff, 3'b100, 15, 1, riscv_pkg::op_i), 15,
                          32'hffff_fffa, 1);
        prog[15] = writes(i_type(12'hffe, 3'b010, 16, 2, riscv_pkg::op_i), 16, 32'd1, 1);
        prog[16] = writes(i_type(12'h004, 3'b001, 17, 1, riscv_pkg::op_i), 17, 32'h50, 1);
        prog[17] = writes(i_type(12'h01c, 3'b101, 18, 2, riscv_pkg::op_i), 18, 32'hf, 1);
        prog[18] = writes(i_type(12'h401, 3'b101, 19, 2, riscv_pkg::op_i), 19,
                          32'hffff_fffe, 1);
        // Dependent chain
        prog[19] = writes(i_type(12'd7, 3'b000, 20, 0, riscv_pkg::op_i), 20, 32'd7, 2);
        prog[20] = writes(r_type(7'h00, 3'b000, 21, 20, 20), 21, 32'd14, 2);
        prog[21] = writes(r_type(7'h00, 3'b000, 22, 21, 20), 22, 32'd21, 2);
        prog[22] = writes(r_type(7'h20, 3'b000, 23, 22, 21), 23, 32'd7, 2);
        // Store then load at 0x108
        prog[23] = writes(i_type(12'h100, 3'b000, 24, 0, riscv_pkg::op_i), 24, 32'h100, 3);
        prog[24] = stores(s_type(12'd8, 24, 22), 32'h108, 32'd21, 3);
        prog[25] = writes(i_type(12'd8, 3'b010, 25, 24, riscv_pkg::op_load), 25, 32'd21, 3);
        // Load use on rs1, then on rs2
        prog[26] = writes(r_type(7'h00, 3'b000, 26, 25, 1), 26, 32'd26, 4);
        prog[27] = writes(i_type(12'd8, 3'b010, 27, 24, riscv_pkg::op_load), 27, 32'd21, 4);
        prog[28] = writes(r_type(7'h20, 3'b000, 28, 1, 27), 28, 32'hffff_fff0, 4);
        // Taken beq skips 31 to 33, not taken beq skips nothing
        prog[29] = writes(i_type(12'd1, 3'b000, 29, 0, riscv_pkg::op_i), 29, 32'd1, 5);
        prog[30] = silent(beq(13'd16, 29, 29), 5);
        prog[31] = silent(i_type(12'h111, 3'b000, 30, 0, riscv_pkg::op_i), 5);
        prog[32] = silent(i_type(12'h222, 3'b000, 30, 0, riscv_pkg::op_i), 5);
        prog[33] = silent(i_type(12'h333, 3'b000, 30, 0, riscv_pkg::op_i), 5);
        prog[34] = silent(beq(13'd8, 29, 0), 5);
        prog[35] = writes(i_type(12'h044, 3'b000, 30, 0, riscv_pkg::op_i), 30, 32'h44, 5);
        prog[36] = writes(r_type(7'h00, 3'b000, 31, 30, 29), 31, 32'h45, 5);
        // x0 takes the write but reads back zero
        prog[37] = writes(i_type(12'h055, 3'b000, 0, 0, riscv_pkg::op_i), 0, 32'h55, 6);
        prog[38] = writes(r_type(7'h00, 3'b000, 3, 0, 1), 3, 32'd5, 6);
        prog[39] = writes(r_type(7'h00, 3'b000, 4, 0, 0), 4, 32'd0, 6);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg, input int test);
        checks++;
        if (got !== exp)
        begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            errors++;
            test_errors[test]++;
        end
    endtask

    ////////////////////
    // Memory models
    ////////////////////

    function automatic logic [31:0] imem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - base_pc) >> 2;
        imem_word = (idx < 64) ? imem[idx] : 32'h0;
    endfunction

    always @(posedge clk)
    begin
        if (instr_req)
            fetched <= imem_word(pc);
        if (dmem.write)
            dmem_arr[dmem.addr[9:2]] <= dmem.wdata;
        if (dmem.read)
            rdata_q <= dmem_arr[dmem.addr[9:2]];
    end

    // Registered outputs reach the core on the falling edge
    always @(negedge clk)
    begin
        instr <= fetched;
        d_rdata <= rdata_q;
    end

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge clk)
    begin
        int idx;
        int t;
        if (!rst)
        begin
            if (!instr_req)
                stall_cycles++;
            if (dmem.read)
                load_reads++;
            if (retire.write)
            begin
                if (ret_q.size() == 0)
                begin
                    $display("Unexpected register write to x%0d at %0t ns", retire.rd, $time);
                    errors++;
                end
                else
                begin
                    idx = ret_q.pop_front();
                    t = prog[idx].test;
                    check_value(32'(retire.rd), 32'(prog[idx].rd),
                                $sformatf("retire rd of entry %0d", idx), t);
                    check_value(retire.data, prog[idx].data,
                                $sformatf("retire data of entry %0d", idx), t);
                    if (idx == last_idx[t])
                    begin
                        // Both loads and their bubbles are behind us here
                        if (t == 4)
                        begin
                            check_value(stall_cycles, load_use_stalls,
                                        "fetch stall cycles", t);
                            check_value(load_reads, load_count, "data memory reads", t);
                        end
                        $display("test %0d %s: %s (%0d errors)", t, test_name[t],
                                 (test_errors[t] == 0) ? "ok" : "failed", test_errors[t]);
                    end
                end
            end
            if (dmem.write)
            begin
                if (store_q.size() == 0)
                begin
                    $display("Unexpected store to %h at %0t ns", dmem.addr, $time);
                    errors++;
                end
                else
                begin
                    idx = store_q.pop_front();
                    check_value(dmem.addr, prog[idx].addr, "store address", prog[idx].test);
                    check_value(dmem.wdata, prog[idx].data, "store data", prog[idx].test);
                end
            end
        end
    end

    // Watchdog
    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout with %0d register writes still missing", ret_q.size());
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        errors = 0;
        checks = 0;
        stall_cycles = 0;
        load_reads = 0;
        rst = 1'b1;
        instr = '0;
        d_rdata = '0;
        fetched = '0;
        rdata_q = '0;
        void'($urandom(32'h4fb1_f9a0));
        test_name[1] = "alu ops";
        test_name[2] = "forwarding";
        test_name[3] = "store load";
        test_name[4] = "load use";
        test_name[5] = "branch";
        test_name[6] = "x0 write";
        for (int t = 1; t <= 6; t++)
        begin
            test_errors[t] = 0;
            last_idx[t] = -1;
        end
        fill_program();
        for (int i = 0; i < 64; i++)
            imem[i] = '0;
        for (int i = 0; i < 256; i++)
            dmem_arr[i] = $urandom;
        // Queue the expected effects in program order
        for (int i = 0; i < prog_len; i++)
        begin
            imem[i] = prog[i].instr;
            if (prog[i].kind == 2'd1)
            begin
                ret_q.push_back(i);
                last_idx[prog[i].test] = i;
            end
            else if (prog[i].kind == 2'd2)
            begin
                store_q.push_back(i);
            end
        end

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (ret_q.size() != 0)
            @(posedge clk);
        // Squashed instructions would show up here
        repeat (20) @(posedge clk);
        if (store_q.size() != 0)
        begin
            $display("Expected store never reached the data memory");
            errors++;
        end
        if (UUT.core_checks.failures != 0)
        begin
            $display("Core assertions failed %0d times", UUT.core_checks.failures);
            errors++;
        end

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- riscv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic stall,
    input wire logic instr_req,
    input wire riscv_pkg::word_t pc,
    input wire riscv_pkg::dmem_req_t dmem,
    input wire riscv_pkg::retire_t retire
);

    int failures = 0;

    // One data access per cycle
    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(dmem.read && dmem.write))
        else
        begin
            failures++;
            $error("dmem read and write asserted together");
        end

    // A load-use bubble never needs a second cycle
    single_stall: assert property (@(posedge clk) disable iff (rst)
        !instr_req |=> instr_req)
        else
        begin
            failures++;
            $error("fetch held for more than one cycle");
        end

    // Pipeline is empty right after reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !retire.write [*4])
        else
        begin
            failures++;
            $error("retire seen too soon after reset");
        end

    pc_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(pc))
        else
        begin
            failures++;
            $error("pc moved during a stall");
        end

endmodule

bind riscv_core riscv_core_assert core_checks (
    .clk(clk), .rst(rst), .stall(stall), .instr_req(instr_req),
    .pc(pc), .dmem(dmem), .retire(retire)
);

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period = 10.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #(period / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core #(
    parameter riscv_pkg::word_t initial_pc = 32'h0040_0000
) (
    input  wire logic clk,
    input  wire logic rst,
    output riscv_pkg::word_t pc,
    output logic instr_req,
    input  wire riscv_pkg::word_t instr,
    output riscv_pkg::dmem_req_t dmem,
    input  wire riscv_pkg::word_t d_rdata,
    output riscv_pkg::retire_t retire
);

    riscv_pkg::word_t id_pc;
    riscv_pkg::word_t rdata1;
    riscv_pkg::word_t rdata2;
    logic stall;
    logic flush_id_ex;
    logic flush_ex_mem;

    riscv_pkg::id_ex_t  id_ex_d, id_ex_q;
    riscv_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    riscv_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    ////////////////////
    // Fetch and decode
    ////////////////////

    fetch_control #(.initial_pc(initial_pc)) fetch (
        .clk(clk), .rst(rst), .stall(stall),
        .redirect(ex_mem_q.taken), .target(ex_mem_q.branch_target),
        .pc(pc), .id_pc(id_pc), .instr_req(instr_req),
        .flush_id_ex(flush_id_ex), .flush_ex_mem(flush_ex_mem)
    );

    instr_decoder decoder (
        .instr(instr), .id_pc(id_pc),
        .ex_ctrl(id_ex_q.ctrl), .ex_rd(id_ex_q.rd), .redirect(ex_mem_q.taken),
        .decoded(id_ex_d), .stall(stall)
    );

    // Read ports line up with the execute stage
    reg_file regs (
        .clk(clk), .rs1(id_ex_d.rs1), .rs2(id_ex_d.rs2), .wr(retire),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    stage_reg #(.payload_t(riscv_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(flush_id_ex),
        .d(id_ex_d), .q(id_ex_q)
    );

    ////////////////////
    // Execute and memory
    ////////////////////

    execute_unit execute (
        .id_ex(id_ex_q), .rdata1(rdata1), .rdata2(rdata2),
        .mem(ex_mem_q), .wb(retire), .result(ex_mem_d)
    );

    stage_reg #(.payload_t(riscv_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(flush_ex_mem),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    assign dmem = '{read: ex_mem_q.ctrl.mem_read, write: ex_mem_q.ctrl.mem_write,
                    addr: ex_mem_q.alu_result, wdata: ex_mem_q.store_data};

    assign mem_wb_d = '{reg_write: ex_mem_q.ctrl.reg_write,
                        mem_to_reg: ex_mem_q.ctrl.mem_to_reg,
                        alu_result: ex_mem_q.alu_result, rd: ex_mem_q.rd};

    stage_reg #(.payload_t(riscv_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // Writeback, load data arrives the cycle after the request
    assign retire = '{write: mem_wb_q.reg_write, rd: mem_wb_q.rd,
                      data: mem_wb_q.mem_to_reg ? d_rdata : mem_wb_q.alu_result};

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire riscv_pkg::id_ex_t id_ex,
    input  wire riscv_pkg::word_t rdata1,
    input  wire riscv_pkg::word_t rdata2,
    input  wire riscv_pkg::ex_mem_t mem,
    input  wire riscv_pkg::retire_t wb,
    output riscv_pkg::ex_mem_t result
);

    riscv_pkg::word_t op_a;
    riscv_pkg::word_t op_rs2;
    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_y;
    logic zero;

    ////////////////////
    // Forwarding
    ////////////////////

    // Youngest producer wins, memory before writeback
    function automatic riscv_pkg::word_t fwd(
        input riscv_pkg::reg_addr_t rs,
        input riscv_pkg::word_t     rf_data,
        input riscv_pkg::ex_mem_t   m,
        input riscv_pkg::retire_t   w
    );
        if (rs == '0)
            fwd = '0;
        else if (m.ctrl.reg_write && (m.rd == rs))
            fwd = m.alu_result;
        else if (w.write && (w.rd == rs))
            fwd = w.data;
        else
            fwd = rf_data;
    endfunction

    assign op_a = fwd(id_ex.rs1, rdata1, mem, wb);
    assign op_rs2 = fwd(id_ex.rs2, rdata2, mem, wb);

    // Store data takes the forwarded rs2, not the immediate
    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_rs2;

    ////////////////////
    // ALU
    ////////////////////

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            riscv_pkg::alu_add: alu_y = op_a + op_b;
            riscv_pkg::alu_sub: alu_y = op_a - op_b;
            riscv_pkg::alu_and: alu_y = op_a & op_b;
            riscv_pkg::alu_or:  alu_y = op_a | op_b;
            riscv_pkg::alu_xor: alu_y = op_a ^ op_b;
            riscv_pkg::alu_slt: alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            riscv_pkg::alu_sll: alu_y = op_a << op_b[4:0];
            riscv_pkg::alu_srl: alu_y = op_a >> op_b[4:0];
            riscv_pkg::alu_sra: alu_y = $signed(op_a) >>> op_b[4:0];
            default:            alu_y = op_a + op_b;
        endcase
    end

    assign zero = (alu_y == '0);

    // Branch outcome travels to memory where it is acted on
    always_comb
    begin
        result.ctrl = id_ex.ctrl;
        result.alu_result = alu_y;
        result.store_data = op_rs2;
        result.branch_target = id_ex.pc + id_ex.imm;
        result.taken = id_ex.ctrl.branch && zero;
        result.rd = id_ex.rd;
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic clk,
    input  wire riscv_pkg::reg_addr_t rs1,
    input  wire riscv_pkg::reg_addr_t rs2,
    input  wire riscv_pkg::retire_t wr,
    output riscv_pkg::word_t rdata1,
    output riscv_pkg::word_t rdata2
);

    riscv_pkg::word_t regs [32];

    // x0 is never stored
    always_ff @(posedge clk)
    begin
        if (wr.write && (wr.rd != '0))
        begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Registered reads, a same-cycle write is passed straight through
    always_ff @(posedge clk)
    begin
        if (rs1 == '0)
            rdata1 <= '0;
        else if (wr.write && (wr.rd == rs1))
            rdata1 <= wr.data;
        else
            rdata1 <= regs[rs1];

        if (rs2 == '0)
            rdata2 <= '0;
        else if (wr.write && (wr.rd == rs2))
            rdata2 <= wr.data;
        else
            rdata2 <= regs[rs2];
    end

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire riscv_pkg::word_t instr,
    input  wire riscv_pkg::word_t id_pc,
    input  wire riscv_pkg::ctrl_t ex_ctrl,
    input  wire riscv_pkg::reg_addr_t ex_rd,
    input  wire logic redirect,
    output riscv_pkg::id_ex_t decoded,
    output logic stall
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7_bit;
    logic use_rs2;
    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_s;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm;
    riscv_pkg::ctrl_t ctrl;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7_bit = instr[30];

    // ALU function from funct3, alt selects sub or sra
    function automatic riscv_pkg::alu_op_t alu_func(input logic [2:0] f3, input logic alt);
        case (f3)
            riscv_pkg::f3_add_sub: alu_func = alt ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
            riscv_pkg::f3_sll:     alu_func = riscv_pkg::alu_sll;
            riscv_pkg::f3_slt:     alu_func = riscv_pkg::alu_slt;
            riscv_pkg::f3_xor:     alu_func = riscv_pkg::alu_xor;
            riscv_pkg::f3_srl_sra: alu_func = alt ? riscv_pkg::alu_sra : riscv_pkg::alu_srl;
            riscv_pkg::f3_or:      alu_func = riscv_pkg::alu_or;
            riscv_pkg::f3_and:     alu_func = riscv_pkg::alu_and;
            default:               alu_func = riscv_pkg::alu_add;
        endcase
    endfunction

    ////////////////////
    // Control decode
    ////////////////////

    always_comb
    begin
        ctrl = '0;
        use_rs2 = 1'b0;
        case (opcode)
            riscv_pkg::op_r:
            begin
                ctrl.alu_op = alu_func(funct3, funct7_bit);
                ctrl.reg_write = 1'b1;
                use_rs2 = 1'b1;
            end
            riscv_pkg::op_i:
            begin
                // Bit 30 is immediate data except for shifts
                ctrl.alu_op = alu_func(funct3,
                                       funct7_bit && (funct3 == riscv_pkg::f3_srl_sra));
                ctrl.alu_src = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            riscv_pkg::op_load:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            riscv_pkg::op_store:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_write = 1'b1;
                use_rs2 = 1'b1;
            end
            riscv_pkg::op_branch:
            begin
                // Only beq is honoured, other branches fall through
                ctrl.alu_op = riscv_pkg::alu_sub;
                ctrl.branch = (funct3 == riscv_pkg::f3_beq);
                use_rs2 = 1'b1;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

    ////////////////////
    // Immediates
    ////////////////////

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb
    begin
        case (opcode)
            riscv_pkg::op_i,
            riscv_pkg::op_load:   imm = imm_i;
            riscv_pkg::op_store:  imm = imm_s;
            riscv_pkg::op_branch: imm = imm_b;
            default:              imm = '0;
        endcase
    end

    assign decoded = '{pc: id_pc, ctrl: ctrl, imm: imm,
                       rs1: instr[19:15], rs2: instr[24:20], rd: instr[11:7]};

    // Load in execute feeding this instruction
    assign stall = ex_ctrl.mem_read && (ex_rd != '0) && !redirect &&
                   ((ex_rd == decoded.rs1) || (use_rs2 && (ex_rd == decoded.rs2)));

endmodule

`default_nettype wire

//--- fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control #(
    parameter riscv_pkg::word_t initial_pc = 32'h0040_0000
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic stall,
    input  wire logic redirect,
    input  wire riscv_pkg::word_t target,
    output riscv_pkg::word_t pc,
    output riscv_pkg::word_t id_pc,
    output logic instr_req,
    output logic flush_id_ex,
    output logic flush_ex_mem
);

    // High for the cycle where decode still sees a stale memory word
    logic refill;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= initial_pc;
            id_pc <= initial_pc;
            refill <= 1'b1;
        end
        else
        begin
            refill <= redirect;
            if (redirect)
            begin
                pc <= target;
                id_pc <= pc;
            end
            else if (!stall)
            begin
                pc <= pc + 32'd4;
                id_pc <= pc;
            end
        end
    end

    // Memory keeps its output while decode is held
    assign instr_req = !stall;

    assign flush_id_ex = stall | redirect | refill;
    assign flush_ex_mem = redirect;

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic hold,
    input  wire logic flush,
    input  wire payload_t d,
    output payload_t q
);

    // Flush turns the slot into a bubble
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            q <= '0;
        end
        else if (!hold)
        begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    ////////////////////
    // Widths and base types
    ////////////////////

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8
    } alu_op_t;

    // Major opcodes
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_i      = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 field values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;

    ////////////////////
    // Stage payloads
    ////////////////////

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    reg_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        word_t     branch_target;
        logic      taken;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        reg_addr_t rd;
    } mem_wb_t;

    // Register write reported at writeback
    typedef struct packed {
        logic      write;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

`default_nettype wire
